// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module fetch_tb -f vlog.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vfetch_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'All tests passed!' && exit 0 || exit 1

// ==== src/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// fetch PC after reset
`define FETCH_PC_RESET 32'h0000_0000

// andi r0, r0, 0
// fills the slot that a fetch block does not supply
`define FETCH_INST_NOP 32'h0340_0000

// log2 of the memory depth in 64-bit blocks
`define IMEM_ADDR_W 6

// entries in the bundle queue
`define IQ_DEPTH 4

`endif

// ==== src/fetch_pc_gen.sv ====
`include "fetch_config.svh"

module fetch_pc_gen (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush,
    input  fetch_pkg::addr_t   flush_pc,
    input  logic               fetch_gnt,
    input  logic               if1_allowin,
    output fetch_pkg::mem_req_t fetch_req
);
    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_seq;
    logic  issue;

    // next aligned fetch block
    assign pc_seq = {pc_q[31:3], 3'b000} + 32'd8;

    // no request in the flush cycle
    // the new target goes out one cycle later
    assign fetch_req.valid = if1_allowin && !flush;
    assign fetch_req.write = 1'b0;
    assign fetch_req.addr  = pc_q;
    assign fetch_req.wdata = '0;

    // read leaves only with the port granted
    assign issue = fetch_req.valid && fetch_gnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= `FETCH_PC_RESET;
        end else if (flush) begin
            // target may be unaligned
            pc_q <= flush_pc;
        end else if (issue) begin
            pc_q <= pc_seq;
        end
    end

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // one memory block
    // lower slot at [31:0], upper slot at [63:32]
    typedef logic [63:0] block_t;

    // request on the memory port
    typedef struct packed {
        logic   valid;
        logic   write;
        addr_t  addr;
        block_t wdata;
    } mem_req_t;

    // read response, one cycle after the read
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        block_t rdata;
        logic   fault;
    } mem_resp_t;

    // entry handed to the decoder
    typedef struct packed {
        addr_t pc;
        addr_t pc_next;
        inst_t inst0;
        inst_t inst1;
        logic  fault;
    } fetch_bundle_t;

endpackage

// ==== src/fetch_top.sv ====
`include "fetch_config.svh"

module fetch_top (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           flush,
    input  fetch_pkg::addr_t               flush_pc,
    input  fetch_pkg::mem_req_t            load_req,
    input  logic                           pop,
    output fetch_pkg::fetch_bundle_t       out_bundle,
    output logic                           out_valid,
    output logic [$clog2(`IQ_DEPTH+1)-1:0] iq_count
);
    import fetch_pkg::*;

    mem_req_t      fetch_req;
    mem_req_t      mem_req;
    mem_resp_t     mem_resp;
    fetch_bundle_t push_data;
    logic          fetch_gnt;
    logic          if1_allowin;
    logic          push;
    logic          iq_full;

    // PC and request
    fetch_pc_gen pc_gen_i (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .fetch_gnt   (fetch_gnt),
        .if1_allowin (if1_allowin),
        .fetch_req   (fetch_req)
    );

    // loader over fetch
    imem_arbiter arbiter_i (
        .clk       (clk),
        .rstn      (rstn),
        .load_req  (load_req),
        .fetch_req (fetch_req),
        .mem_req   (mem_req),
        .fetch_gnt (fetch_gnt)
    );

    inst_mem mem_i (
        .clk      (clk),
        .rstn     (rstn),
        .flush    (flush),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    // slot alignment and skid
    if1_stage if1_i (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .mem_resp    (mem_resp),
        .iq_full     (iq_full),
        .if1_allowin (if1_allowin),
        .push        (push),
        .push_data   (push_data)
    );

    // bundles for the decoder
    inst_queue queue_i (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .out_bundle (out_bundle),
        .out_valid  (out_valid),
        .iq_full    (iq_full),
        .iq_count   (iq_count)
    );

endmodule

// ==== src/if1_stage.sv ====
`include "fetch_config.svh"

module if1_stage (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  fetch_pkg::mem_resp_t     mem_resp,
    input  logic                     iq_full,
    output logic                     if1_allowin,
    output logic                     push,
    output fetch_pkg::fetch_bundle_t push_data
);
    import fetch_pkg::*;

    fetch_bundle_t resp_bundle;
    fetch_bundle_t main_q;
    fetch_bundle_t skid_q;
    logic          main_v;
    logic          skid_v;
    logic          hold;
    addr_t         pc_aligned;

    // slot select by PC bit 2
    assign pc_aligned = {mem_resp.pc[31:3], 3'b000};

    always_comb begin
        resp_bundle.pc      = mem_resp.pc;
        resp_bundle.pc_next = pc_aligned + 32'd8;
        resp_bundle.fault   = mem_resp.fault;
        if (mem_resp.pc[2]) begin
            // entry in the upper half, lower slot unused
            resp_bundle.inst0 = mem_resp.rdata[63:32];
            resp_bundle.inst1 = `FETCH_INST_NOP;
        end else begin
            resp_bundle.inst0 = mem_resp.rdata[31:0];
            resp_bundle.inst1 = mem_resp.rdata[63:32];
        end
    end

    // main entry stuck behind a full queue
    assign hold = main_v && iq_full;

    assign push      = main_v && !iq_full;
    assign push_data = main_q;

    // stop fetch while the skid is taken,
    // and already in the cycle that fills it
    assign if1_allowin = !skid_v && !(hold && mem_resp.valid);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            main_v <= 1'b0;
            skid_v <= 1'b0;
        end else if (flush) begin
            // in-flight response dropped too
            main_v <= 1'b0;
            skid_v <= 1'b0;
        end else if (skid_v) begin
            // queue drained, skid moves up
            if (!iq_full) begin
                skid_v <= 1'b0;
            end
        end else if (hold) begin
            if (mem_resp.valid) begin
                skid_v <= 1'b1;
            end
        end else begin
            // main empty or pushed this cycle
            main_v <= mem_resp.valid;
        end
    end

    // payload, same priority as above
    always_ff @(posedge clk) begin
        if (skid_v) begin
            if (!iq_full) begin
                main_q <= skid_q;
            end
        end else if (hold) begin
            if (mem_resp.valid) begin
                skid_q <= resp_bundle;
            end
        end else if (mem_resp.valid) begin
            main_q <= resp_bundle;
        end
    end

endmodule

// ==== src/imem_arbiter.sv ====
module imem_arbiter (
    input  logic                clk,
    input  logic                rstn,
    input  fetch_pkg::mem_req_t load_req,
    input  fetch_pkg::mem_req_t fetch_req,
    output fetch_pkg::mem_req_t mem_req,
    output logic                fetch_gnt
);

    // owner of the port in the last cycle
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_LOAD
    } owner_e;

    owner_e owner_q;
    owner_e owner_d;

    // loader first
    // fetch also waits one cycle after a loader access,
    // so a read never lands right behind a write
    assign fetch_gnt = !load_req.valid && (owner_q != OWN_LOAD);

    // winner forwarded as one struct
    always_comb begin
        if (load_req.valid) begin
            mem_req = load_req;
        end else if (fetch_gnt) begin
            mem_req = fetch_req;
        end else begin
            mem_req = '0;
        end
    end

    always_comb begin
        if (load_req.valid) begin
            owner_d = OWN_LOAD;
        end else if (fetch_req.valid && fetch_gnt) begin
            owner_d = OWN_FETCH;
        end else begin
            owner_d = OWN_NONE;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

endmodule

// ==== src/inst_mem.sv ====
`include "fetch_config.svh"

module inst_mem (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  fetch_pkg::mem_req_t  mem_req,
    output fetch_pkg::mem_resp_t mem_resp
);
    import fetch_pkg::*;

    localparam int DEPTH = 1 << `IMEM_ADDR_W;

    block_t mem [DEPTH];

    logic [`IMEM_ADDR_W-1:0] index;
    logic                    in_range;
    logic                    rd_en;

    // block index from the byte address
    assign index    = mem_req.addr[`IMEM_ADDR_W+2:3];
    // anything above the depth faults
    assign in_range = (mem_req.addr[31:`IMEM_ADDR_W+3] == '0);
    assign rd_en    = mem_req.valid && !mem_req.write;

    // out-of-range loader writes dropped
    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.write && in_range) begin
            mem[index] <= mem_req.wdata;
        end
    end

    // response one cycle after the read
    // flush drops the valid
    // payload carries the request PC back
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_resp <= '0;
        end else begin
            mem_resp.valid <= rd_en && !flush;
            if (rd_en) begin
                mem_resp.pc    <= mem_req.addr;
                mem_resp.fault <= !in_range;
                mem_resp.rdata <= in_range ? mem[index] : {`FETCH_INST_NOP, `FETCH_INST_NOP};
            end
        end
    end

endmodule

// ==== src/inst_queue.sv ====
`include "fetch_config.svh"

module inst_queue (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               flush,
    input  logic                               push,
    input  fetch_pkg::fetch_bundle_t           push_data,
    input  logic                               pop,
    output fetch_pkg::fetch_bundle_t           out_bundle,
    output logic                               out_valid,
    output logic                               iq_full,
    output logic [$clog2(`IQ_DEPTH+1)-1:0]     iq_count
);
    import fetch_pkg::*;

    localparam int DEPTH = `IQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    fetch_bundle_t entries [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic do_push;
    logic do_pop;

    assign out_valid  = (count != '0);
    assign iq_full    = (count == cnt_t'(DEPTH));
    assign iq_count   = count;
    assign out_bundle = entries[rd_ptr];

    // pop on empty ignored
    assign do_push = push && !iq_full;
    assign do_pop  = pop && out_valid;

    // wrap at depth, not only at a power of two
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        if (ptr == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + ptr_t'(1);
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // both at once leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + cnt_t'(1);
            end else if (do_pop && !do_push) begin
                count <= count - cnt_t'(1);
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== testbench/fetch_tb.sv ====
`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    typedef logic [$clog2(`IQ_DEPTH+1)-1:0] count_t;

    // one row of the test table
    typedef struct packed {
        addr_t       target;
        logic        slow_pop;
        logic [15:0] n_bundles;
        logic        inject;
    } test_row_t;

    localparam int    NUM_TESTS   = 6;
    localparam int    MEM_BLOCKS  = 1 << `IMEM_ADDR_W;
    localparam addr_t MEM_BYTES   = addr_t'(MEM_BLOCKS * 8);
    // mid-run writes land this far past the queue head
    localparam int    WRITE_AHEAD = 12;
    // faulting address that parks fetch during the load
    localparam addr_t PARK_PC     = 32'h0000_4000;

    string test_name [NUM_TESTS] = '{
        "seq_aligned", "unaligned_start", "slow_pop",
        "loader_writes", "out_of_range", "flush_mid_run"
    };
    // target, slow pop, bundles to check, loader writes
    test_row_t tests [NUM_TESTS] = '{
        '{32'h0000_0000, 1'b0, 16'd40, 1'b0},
        '{32'h0000_0104, 1'b0, 16'd20, 1'b0},
        '{32'h0000_0040, 1'b1, 16'd40, 1'b0},
        '{32'h0000_0000, 1'b0, 16'd40, 1'b1},
        '{32'h0000_0a00, 1'b0, 16'd12, 1'b0},
        '{32'h0000_0148, 1'b0, 16'd16, 1'b0}
    };

    logic          clk = 1'b0;
    logic          rstn;
    logic          flush;
    addr_t         flush_pc;
    mem_req_t      load_req;
    logic          pop;
    fetch_bundle_t out_bundle;
    logic          out_valid;
    count_t        iq_count;

    // program image with the lower slot at even index
    inst_t         prog [2 * MEM_BLOCKS];
    logic [31:0]   rng_state = 32'hef9e_c9c9;
    int            cycle_count = 0;
    int            fail_count = 0;

    fetch_top fetch_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .load_req   (load_req),
        .pop        (pop),
        .out_bundle (out_bundle),
        .out_valid  (out_valid),
        .iq_count   (iq_count)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reference model for one bundle
    function automatic fetch_bundle_t expected_bundle(input addr_t pc);
        fetch_bundle_t b;
        inst_t         lower;
        inst_t         upper;
        int            blk;
        blk       = int'(pc >> 3);
        b.pc      = pc;
        // start of the following 8-byte block
        b.pc_next = pc - (pc & 32'h7) + 32'd8;
        b.fault   = (pc >= MEM_BYTES);
        lower     = b.fault ? `FETCH_INST_NOP : prog[2 * blk];
        upper     = b.fault ? `FETCH_INST_NOP : prog[2 * blk + 1];
        // entry at bit 2 starts in the upper slot
        b.inst0   = pc[2] ? upper : lower;
        b.inst1   = pc[2] ? `FETCH_INST_NOP : upper;
        return b;
    endfunction

    function automatic mem_req_t write_request(input int blk);
        mem_req_t r;
        r.valid = 1'b1;
        r.write = 1'b1;
        r.addr  = addr_t'(blk * 8);
        r.wdata = {prog[2 * blk + 1], prog[2 * blk]};
        return r;
    endfunction

    // slow pop worst case plus margin
    function automatic int timeout_cycles();
        int total;
        total = 0;
        foreach (tests[i]) begin
            total += int'(tests[i].n_bundles);
        end
        return total * 4 + 200;
    endfunction

    task automatic report_failure(input string what);
        fail_count++;
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    // field order pc, pc_next, inst0, inst1, fault
    task automatic check_bundle(input string name, input fetch_bundle_t exp,
                                input fetch_bundle_t act);
        if (act !== exp) begin
            $display("ERROR: %s expected %h_%h_%h_%h_%b actual %h_%h_%h_%h_%b", name,
                     exp.pc, exp.pc_next, exp.inst0, exp.inst1, exp.fault,
                     act.pc, act.pc_next, act.inst0, act.inst1, act.fault);
            report_failure("bundle mismatch at the queue output");
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("ERROR: %s iq_count expected %0d actual %0d", name, exp, act);
            report_failure("queue count mismatch");
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR: %s out_valid expected %b actual %b", name, exp, act);
            report_failure("out_valid mismatch");
        end
    endtask

    task automatic pulse_flush(input addr_t target);
        @(posedge clk);
        flush    <= 1'b1;
        flush_pc <= target;
        pop      <= 1'b0;
        load_req <= '0;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // one block per cycle while the loader owns the port
    task automatic load_program();
        for (int b = 0; b < MEM_BLOCKS; b++) begin
            @(posedge clk);
            load_req <= write_request(b);
        end
    endtask

    task automatic run_test(input int idx);
        test_row_t     row;
        fetch_bundle_t exp;
        addr_t         exp_pc;
        int            got;
        int            cyc;
        int            wb;
        row    = tests[idx];
        exp_pc = row.target;
        got    = 0;
        cyc    = 0;
        pulse_flush(row.target);
        // queue empty right after the flush edge
        @(negedge clk);
        check_valid(test_name[idx], 1'b0, out_valid);
        check_count(test_name[idx], '0, iq_count);
        while (got < int'(row.n_bundles)) begin
            @(posedge clk);
            if (row.slow_pop) begin
                pop <= (cyc % 4 == 3);
            end else begin
                pop <= 1'b1;
            end
            // rewrite a block well ahead of fetch
            wb = int'(exp_pc >> 3) + WRITE_AHEAD;
            if (row.inject && (cyc % 6 == 2) && (wb < MEM_BLOCKS)) begin
                rng_state        = xorshift32(rng_state);
                prog[2 * wb]     = rng_state;
                rng_state        = xorshift32(rng_state);
                prog[2 * wb + 1] = rng_state;
                load_req <= write_request(wb);
            end else begin
                load_req <= '0;
            end
            @(negedge clk);
            if (iq_count > count_t'(`IQ_DEPTH)) begin
                report_failure($sformatf("%s: queue count %0d above its depth",
                                         test_name[idx], iq_count));
            end
            // head leaves at the next edge
            if (pop && out_valid) begin
                exp = expected_bundle(exp_pc);
                check_bundle(test_name[idx], exp, out_bundle);
                exp_pc = exp.pc_next;
                got++;
            end
            cyc++;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_cycles()) begin
            report_failure("run timed out waiting for bundles");
        end
    end

    initial begin
        rstn     = 1'b0;
        flush    = 1'b0;
        flush_pc = '0;
        load_req = '0;
        pop      = 1'b0;
        for (int i = 0; i < 2 * MEM_BLOCKS; i++) begin
            rng_state = xorshift32(rng_state);
            prog[i]   = rng_state;
        end
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        pulse_flush(PARK_PC);
        load_program();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_failure("checks failed during the run");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/imem_arbiter.sv
src/inst_mem.sv
src/if1_stage.sv
src/inst_queue.sv
src/fetch_top.sv
testbench/fetch_tb.sv
